/* logic/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	localparam int IMEM_DEPTH = 64;
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f
	} opT;

	// SPECIAL function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL   = 6'h00,
		FN_JR    = 6'h08,
		FN_BREAK = 6'h0d,
		FN_ADDU  = 6'h21,
		FN_SUBU  = 6'h23,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_SLT   = 6'h2a
	} funcT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluFuncT;

	typedef struct packed {
		logic    regWrite;
		logic    aluSrcImm;
		logic    zeroExt;
		aluFuncT aluFunc;
		logic    branch;
		logic    branchNe;
		logic    jump;
		logic    jr;
		logic    brk;
	} ctlT;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} fetchDataT;

	typedef struct packed {
		wordT       pc;
		ctlT        ctl;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    wrReg;
		logic [4:0] shamt;
		wordT       extImm;
		wordT       srcA;
		wordT       srcB;
	} decodeDataT;

	typedef enum logic {
		regSel,
		execSel
	} fwdSelT;

	typedef struct packed {
		logic    valid;
		wordT    pc;
		logic    wrEn;
		regAddrT wrReg;
		wordT    wrData;
	} retireT;

	typedef struct packed {
		logic               en;
		logic [IMEM_AW-1:0] addr;
		wordT               data;
	} imemWrT;

endpackage

`default_nettype wire

/* logic/pipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeReg import mipsPkg::*; #(
	parameter type payloadT = logic
) (
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire logic    run,
	input  wire logic    inValid,
	input  wire payloadT inData,
	output logic         outValid,
	output payloadT      outData
);

	// payload follows the valid bit but needs no reset
	always_ff @(posedge clk) begin
		if (run) begin
			outData <= inData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (run) begin
			outValid <= inValid;
		end
	end

	// downstream stages qualify everything with this bit
	assert property (@(posedge clk) disable iff (!rstN) !$isunknown(outValid));

endmodule

`default_nettype wire

/* logic/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import mipsPkg::*; (
	input  wire logic   clk,
	input  wire logic   rstN,
	input  wire logic   run,
	input  wire imemWrT imemWr,
	input  wire logic   redirect,
	input  wire wordT   redirectPc,
	output logic        fetchValid,
	output fetchDataT   fetchData
);

	wordT pc;
	wordT mem [IMEM_DEPTH];
	logic [IMEM_AW-1:0] wordIdx;

	// load port, only while the core is stopped
	always_ff @(posedge clk) begin
		if (imemWr.en && !run) begin
			mem[imemWr.addr] <= imemWr.data;
		end
	end

	// program counter
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (run) begin
			if (redirect) begin
				pc <= redirectPc;
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

	// word index, upper PC bits wrap onto the small memory
	assign wordIdx = pc[IMEM_AW+1:2];

	assign fetchData.instr   = mem[wordIdx];
	assign fetchData.pcPlus4 = pc + 32'd4;
	assign fetchValid        = run;

endmodule

`default_nettype wire

/* logic/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode import mipsPkg::*; (
	input  wire logic      inValid,
	input  wire fetchDataT dataF,
	input  wire wordT      rdA,
	input  wire wordT      rdB,
	output regAddrT        raA,
	output regAddrT        raB,
	input  wire fwdSelT    fwdA,
	input  wire fwdSelT    fwdB,
	input  wire wordT      resultE,
	output decodeDataT     dataD,
	output logic           outValid,
	output logic           redirect,
	output wordT           redirectPc
);

	opT op;
	funcT funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	regAddrT dest;
	logic [15:0] imm;
	ctlT ctlRaw;
	ctlT ctl;
	wordT extImm;
	wordT srcA;
	wordT srcB;
	wordT branchTarget;
	wordT jumpTarget;
	logic srcEqual;
	logic taken;

	assign op    = opT'(dataF.instr[31:26]);
	assign funct = funcT'(dataF.instr[5:0]);
	assign rs    = dataF.instr[25:21];
	assign rt    = dataF.instr[20:16];
	assign rd    = dataF.instr[15:11];
	assign imm   = dataF.instr[15:0];

	// main decoder
	always_comb begin
		ctlRaw = '0;
		ctlRaw.aluFunc = ALU_ADD;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADDU: ctlRaw.regWrite = 1'b1;
					FN_SUBU: {ctlRaw.regWrite, ctlRaw.aluFunc} = {1'b1, ALU_SUB};
					FN_AND:  {ctlRaw.regWrite, ctlRaw.aluFunc} = {1'b1, ALU_AND};
					FN_OR:   {ctlRaw.regWrite, ctlRaw.aluFunc} = {1'b1, ALU_OR};
					FN_SLT:  {ctlRaw.regWrite, ctlRaw.aluFunc} = {1'b1, ALU_SLT};
					FN_SLL:  {ctlRaw.regWrite, ctlRaw.aluFunc} = {1'b1, ALU_SLL};
					FN_JR:   ctlRaw.jr = 1'b1;
					FN_BREAK: ctlRaw.brk = 1'b1;
					default: ;
				endcase
			end
			OP_ADDIU: {ctlRaw.regWrite, ctlRaw.aluSrcImm} = 2'b11;
			OP_ORI: begin
				{ctlRaw.regWrite, ctlRaw.aluSrcImm, ctlRaw.zeroExt} = 3'b111;
				ctlRaw.aluFunc = ALU_OR;
			end
			OP_LUI: begin
				{ctlRaw.regWrite, ctlRaw.aluSrcImm} = 2'b11;
				ctlRaw.aluFunc = ALU_LUI;
			end
			OP_BEQ: ctlRaw.branch = 1'b1;
			OP_BNE: {ctlRaw.branch, ctlRaw.branchNe} = 2'b11;
			OP_J:   ctlRaw.jump = 1'b1;
			// anything else retires without a write
			default: ;
		endcase
	end

	// writes to r0 are dropped here, so later stages see no write
	assign dest = (op == OP_SPECIAL) ? rd : rt;

	always_comb begin
		ctl = ctlRaw;
		ctl.regWrite = ctlRaw.regWrite && (dest != '0);
	end

	assign extImm = ctl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	// operands, bypassing the execute result
	assign raA  = rs;
	assign raB  = rt;
	assign srcA = (fwdA == execSel) ? resultE : rdA;
	assign srcB = (fwdB == execSel) ? resultE : rdB;

	assign srcEqual     = (srcA == srcB);
	assign taken        = ctl.branch && (ctl.branchNe ? !srcEqual : srcEqual);
	assign branchTarget = dataF.pcPlus4 + {extImm[29:0], 2'b00};
	assign jumpTarget   = {dataF.pcPlus4[31:28], dataF.instr[25:0], 2'b00};

	assign redirect   = inValid && (taken || ctl.jump || ctl.jr);
	assign redirectPc = ctl.jr ? srcA : (ctl.jump ? jumpTarget : branchTarget);

	assign dataD.pc     = dataF.pcPlus4 - 32'd4;
	assign dataD.ctl    = ctl;
	assign dataD.rs     = rs;
	assign dataD.rt     = rt;
	assign dataD.wrReg  = ctl.regWrite ? dest : '0;
	assign dataD.shamt  = dataF.instr[10:6];
	assign dataD.extImm = extImm;
	assign dataD.srcA   = srcA;
	assign dataD.srcB   = srcB;
	assign outValid     = inValid;

	// redirectPc priority assumes at most one kind of control transfer
	always_comb begin
		assert ($onehot0({ctl.branch, ctl.jump, ctl.jr}));
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire regAddrT raA,
	input  wire regAddrT raB,
	output wordT         rdA,
	output wordT         rdB,
	input  wire logic    wrEn,
	input  wire regAddrT wrReg,
	input  wire wordT    wrData
);

	wordT regs [32];

	// registers start from zero, so programs see a known state
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrReg != '0)) begin
			regs[wrReg] <= wrData;
		end
	end

	// r0 reads zero; a same-cycle write is passed straight through
	assign rdA = (raA == '0) ? '0 :
		(wrEn && (wrReg == raA)) ? wrData : regs[raA];
	assign rdB = (raB == '0) ? '0 :
		(wrEn && (wrReg == raB)) ? wrData : regs[raB];

endmodule

`default_nettype wire

/* logic/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute import mipsPkg::*; (
	input  wire logic       clk,
	input  wire logic       rstN,
	input  wire logic       inValid,
	input  wire decodeDataT dataE,
	output wordT            resultE,
	output logic            wrEnE,
	output regAddrT         wrRegE,
	output logic            brkE,
	output retireT          retire
);

	wordT opB;
	logic stopped;

	assign opB = dataE.ctl.aluSrcImm ? dataE.extImm : dataE.srcB;

	// ALU
	always_comb begin
		case (dataE.ctl.aluFunc)
			ALU_ADD: resultE = dataE.srcA + opB;
			ALU_SUB: resultE = dataE.srcA - opB;
			ALU_AND: resultE = dataE.srcA & opB;
			ALU_OR:  resultE = dataE.srcA | opB;
			ALU_SLT: resultE = {31'd0, $signed(dataE.srcA) < $signed(opB)};
			ALU_SLL: resultE = dataE.srcB << dataE.shamt;
			ALU_LUI: resultE = {dataE.extImm[15:0], 16'h0000};
			default: resultE = '0;
		endcase
	end

	// once BREAK has retired the frozen stage must stay quiet
	always_ff @(posedge clk) begin
		if (!rstN) begin
			stopped <= 1'b0;
		end else if (brkE) begin
			stopped <= 1'b1;
		end
	end

	assign wrEnE  = inValid && dataE.ctl.regWrite && !stopped;
	assign wrRegE = dataE.wrReg;
	assign brkE   = inValid && dataE.ctl.brk && !stopped;

	// retire trace, one cycle behind execute
	always_ff @(posedge clk) begin
		retire.pc     <= dataE.pc;
		retire.wrEn   <= wrEnE;
		retire.wrReg  <= wrEnE ? wrRegE : '0;
		retire.wrData <= wrEnE ? resultE : '0;
		if (!rstN) begin
			retire.valid <= 1'b0;
		end else begin
			retire.valid <= inValid && !stopped;
		end
	end

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
	input  wire regAddrT rs,
	input  wire regAddrT rt,
	input  wire logic    wrEnE,
	input  wire regAddrT wrRegE,
	output fwdSelT       fwdA,
	output fwdSelT       fwdB
);

	// bypass the execute result to a matching source
	always_comb begin
		fwdA = regSel;
		fwdB = regSel;
		if (wrEnE && (wrRegE == rs)) begin
			fwdA = execSel;
		end
		if (wrEnE && (wrRegE == rt)) begin
			fwdB = execSel;
		end
	end

	// decode drops r0 writes, so execute must never ask to forward one
	always_comb begin
		assert (((fwdA != execSel) && (fwdB != execSel)) || (wrRegE != '0));
	end

endmodule

`default_nettype wire

/* logic/runCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module runCtrl import mipsPkg::*; (
	input  wire logic clk,
	input  wire logic rstN,
	input  wire logic start,
	input  wire logic brkE,
	input  wire logic imemWrEn,
	output logic      run,
	output logic      halted
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HALT
	} stateT;

	stateT state;
	stateT nextState;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (start) nextState = RUN;
			// BREAK in execute stops the core on this edge
			RUN:  if (brkE) nextState = HALT;
			// only reset leaves halt
			default: nextState = state;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	assign run    = (state == RUN);
	assign halted = (state == HALT);

	// program memory is only loaded before start
	assert property (@(posedge clk) disable iff (!rstN) imemWrEn |-> state == IDLE);

endmodule

`default_nettype wire

/* logic/mipsLite.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsLite import mipsPkg::*; (
	input  wire logic   clk,
	input  wire logic   rstN,
	input  wire imemWrT imemWr,
	input  wire logic   start,
	output retireT      retire,
	output logic        halted
);

	logic run;
	logic fetchValid;
	fetchDataT fetchData;
	logic validD;
	fetchDataT dataF;
	logic redirect;
	wordT redirectPc;
	regAddrT raA;
	regAddrT raB;
	wordT rdA;
	wordT rdB;
	fwdSelT fwdA;
	fwdSelT fwdB;
	decodeDataT dataD;
	logic validDOut;
	logic validE;
	decodeDataT dataE;
	wordT resultE;
	logic wrEnE;
	regAddrT wrRegE;
	logic brkE;

	runCtrl uRunCtrl (.clk, .rstN, .start, .brkE, .imemWrEn(imemWr.en), .run, .halted);

	fetchUnit uFetch (.clk, .rstN, .run, .imemWr, .redirect, .redirectPc,
		.fetchValid, .fetchData);

	pipeReg #(.payloadT(fetchDataT)) uFd (.clk, .rstN, .run, .inValid(fetchValid),
		.inData(fetchData), .outValid(validD), .outData(dataF));

	decode uDecode (.inValid(validD), .dataF, .rdA, .rdB, .raA, .raB, .fwdA, .fwdB,
		.resultE, .dataD, .outValid(validDOut), .redirect, .redirectPc);

	regFile uRegFile (.clk, .rstN, .raA, .raB, .rdA, .rdB, .wrEn(wrEnE), .wrReg(wrRegE),
		.wrData(resultE));

	hazardUnit uHazard (.rs(dataD.rs), .rt(dataD.rt), .wrEnE, .wrRegE, .fwdA, .fwdB);

	pipeReg #(.payloadT(decodeDataT)) uDe (.clk, .rstN, .run, .inValid(validDOut),
		.inData(dataD), .outValid(validE), .outData(dataE));

	execute uExecute (.clk, .rstN, .inValid(validE), .dataE, .resultE, .wrEnE, .wrRegE,
		.brkE, .retire);

endmodule

`default_nettype wire

/* tb/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// program image and the retire stream it should produce
wordT progMem [IMEM_DEPTH];
int progLen;
retireT expQ [$];
logic modelOk;

function automatic wordT rType(regAddrT rs, regAddrT rt, regAddrT rd, logic [4:0] sh,
		logic [5:0] fn);
	return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic wordT iType(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit(wordT w);
	progMem[IMEM_AW'(progLen)] = w;
	progLen++;
endtask

// plain instruction with sources r0..r8 and destination mostly r1..r8
function automatic wordT randAlu();
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	logic [15:0] imm;
	rs = 5'($urandom_range(0, 8));
	rt = 5'($urandom_range(0, 8));
	rd = ($urandom_range(0, 15) == 0) ? 5'd0 : 5'($urandom_range(1, 8));
	imm = 16'($urandom);
	case ($urandom_range(0, 9))
		0: return rType(rs, rt, rd, 5'd0, FN_ADDU);
		1: return rType(rs, rt, rd, 5'd0, FN_SUBU);
		2: return rType(rs, rt, rd, 5'd0, FN_AND);
		3: return rType(rs, rt, rd, 5'd0, FN_OR);
		4: return rType(rs, rt, rd, 5'd0, FN_SLT);
		5: return rType(5'd0, rt, rd, 5'($urandom), FN_SLL);
		6: return iType(OP_ADDIU, rs, rd, imm);
		7: return iType(OP_ORI, rs, rd, imm);
		8: return iType(OP_LUI, 5'd0, rd, imm);
		// ANDI is outside the subset
		default: return iType(6'h0c, rs, rd, imm);
	endcase
endfunction

// transfers go forward only and each has a plain delay slot
task automatic genProgram();
	int limit;
	int skip;
	int kind;
	regAddrT rs;
	regAddrT rt;
	progLen = 0;
	limit = $urandom_range(24, IMEM_DEPTH - 2);
	while (progLen < limit) begin
		kind = $urandom_range(0, 9);
		skip = $urandom_range(0, 3);
		rs = 5'($urandom_range(0, 8));
		// equal sources make taken BEQ and untaken BNE likely
		rt = ($urandom_range(0, 2) == 0) ? rs : 5'($urandom_range(0, 8));
		if (kind < 6 || progLen + 3 + skip > limit) begin
			emit(randAlu());
		end else begin
			case (kind)
				6: emit(iType(OP_BEQ, rs, rt, 16'(skip + 1)));
				7: emit(iType(OP_BNE, rs, rt, 16'(skip + 1)));
				8: emit({OP_J, 26'(progLen + 2 + skip)});
				default: begin
					// r31 is loaded right before JR so it comes through forwarding
					emit(iType(OP_ORI, 5'd0, 5'd31, 16'((progLen + 3 + skip) * 4)));
					emit(rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
				end
			endcase
			// delay slot and the words a taken transfer skips
			repeat (skip + 1) begin
				emit(randAlu());
			end
		end
	end
	emit(rType(5'd0, 5'd0, 5'd0, 5'd0, FN_BREAK));
	emit(32'h0000_0000);
endtask

// architectural execution; the pc/npc pair gives the delay slot
task automatic runModel();
	wordT regs [32];
	wordT pc;
	wordT npc;
	wordT target;
	wordT instr;
	wordT a;
	wordT b;
	wordT res;
	logic [15:0] imm;
	regAddrT dest;
	logic writes;
	logic brk;
	retireT e;
	int steps;
	regs = '{default: '0};
	expQ.delete();
	modelOk = 1'b0;
	pc = '0;
	npc = 32'd4;
	for (steps = 0; steps < IMEM_DEPTH && !modelOk; steps++) begin
		instr = progMem[pc[IMEM_AW+1:2]];
		a = regs[instr[25:21]];
		b = regs[instr[20:16]];
		imm = instr[15:0];
		res = '0;
		writes = 1'b0;
		brk = 1'b0;
		dest = instr[20:16];
		target = npc + 32'd4;
		case (instr[31:26])
			OP_SPECIAL: begin
				dest = instr[15:11];
				case (instr[5:0])
					FN_ADDU: {writes, res} = {1'b1, a + b};
					FN_SUBU: {writes, res} = {1'b1, a - b};
					FN_AND:  {writes, res} = {1'b1, a & b};
					FN_OR:   {writes, res} = {1'b1, a | b};
					FN_SLT:  {writes, res} = {1'b1, 31'd0, $signed(a) < $signed(b)};
					FN_SLL:  {writes, res} = {1'b1, b << instr[10:6]};
					FN_JR:   target = a;
					FN_BREAK: brk = 1'b1;
					default: ;
				endcase
			end
			OP_ADDIU: {writes, res} = {1'b1, a + {{16{imm[15]}}, imm}};
			OP_ORI:   {writes, res} = {1'b1, a | {16'h0000, imm}};
			OP_LUI:   {writes, res} = {1'b1, imm, 16'h0000};
			OP_BEQ: if (a == b) target = npc + {{14{imm[15]}}, imm, 2'b00};
			OP_BNE: if (a != b) target = npc + {{14{imm[15]}}, imm, 2'b00};
			OP_J:   target = {npc[31:28], instr[25:0], 2'b00};
			default: ;
		endcase
		e.valid = 1'b1;
		e.pc = pc;
		e.wrEn = writes && (dest != 5'd0);
		e.wrReg = e.wrEn ? dest : 5'd0;
		e.wrData = e.wrEn ? res : '0;
		expQ.push_back(e);
		if (e.wrEn) begin
			regs[dest] = res;
		end
		modelOk = brk;
		pc = npc;
		npc = target;
	end
endtask

`endif

/* tb/tbMipsLite.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsLite import mipsPkg::*; ();

	localparam int NUM_PROGS = 20;
	localparam int RESET_CYCLES = 10;
	localparam int QUIET_CYCLES = 10;
	// per program: run and halt window, then reset, load and start
	localparam int CYCLE_LIMIT = NUM_PROGS * (IMEM_DEPTH + 20)
		+ NUM_PROGS * (RESET_CYCLES + IMEM_DEPTH + QUIET_CYCLES + 4);

	logic clk;
	logic rstN;
	imemWrT imemWr;
	logic start;
	retireT retire;
	logic halted;
	int cycleCount = 0;
	int progNum;

	`include "isaModel.svh"

	mipsLite u_mipsLite (.clk, .rstN, .imemWr, .start, .retire, .halted);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("timeout: no finish after %0d cycles, program %0d", cycleCount, progNum);
			$display("tests failed");
			$fatal(1, "simulation did not finish within the cycle limit");
		end
	end

	task automatic checkVal(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t: program %0d, %s is %h, expected %h", $time, progNum,
				what, actual, expected);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkVal("retire.valid after reset", 32'(retire.valid), 32'd0);
		checkVal("halted after reset", 32'(halted), 32'd0);
	endtask

	// one word per cycle over the load port
	task automatic loadProgram();
		int i;
		for (i = 0; i < progLen; i++) begin
			imemWr.en = 1'b1;
			imemWr.addr = IMEM_AW'(i);
			imemWr.data = progMem[IMEM_AW'(i)];
			@(posedge clk);
			#1;
		end
		imemWr = '0;
	endtask

	task automatic runProgram();
		int idx;
		retireT e;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		// pipeline fill, nothing retires yet
		repeat (2) begin
			@(posedge clk);
			#1;
			checkVal("retire.valid during fill", 32'(retire.valid), 32'd0);
		end
		for (idx = 0; idx < expQ.size(); idx++) begin
			e = expQ[idx];
			@(posedge clk);
			#1;
			checkVal("retire.valid", 32'(retire.valid), 32'd1);
			checkVal("retire.pc", retire.pc, e.pc);
			checkVal("retire.wrEn", 32'(retire.wrEn), 32'(e.wrEn));
			checkVal("retire.wrReg", 32'(retire.wrReg), 32'(e.wrReg));
			checkVal("retire.wrData", retire.wrData, e.wrData);
			// halted rises with the last retire, the BREAK
			checkVal("halted", 32'(halted), (idx == expQ.size() - 1) ? 32'd1 : 32'd0);
		end
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			#1;
			checkVal("retire.valid after halt", 32'(retire.valid), 32'd0);
			checkVal("halted after halt", 32'(halted), 32'd1);
		end
	endtask

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		imemWr = '0;
		progNum = 0;
		void'($urandom(32'ha74e));
		for (progNum = 0; progNum < NUM_PROGS; progNum++) begin
			applyReset();
			genProgram();
			runModel();
			checkVal("model reached BREAK", 32'(modelOk), 32'd1);
			loadProgram();
			runProgram();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* mipsLite.f */
+incdir+tb
logic/mipsPkg.sv
logic/pipeReg.sv
logic/fetchUnit.sv
logic/decode.sv
logic/regFile.sv
logic/execute.sv
logic/hazardUnit.sv
logic/runCtrl.sv
logic/mipsLite.sv
tb/tbMipsLite.sv

/* Makefile */
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/VtbMipsLite

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): mipsLite.f $(wildcard logic/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	verilator --binary --timing --assert -j 0 --top-module tbMipsLite \
		-f mipsLite.f -Mdir $(OBJ_DIR) -o VtbMipsLite

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
